//--- hdl/pmod_enc_pkg.sv
package pmod_enc_pkg;

    //////////////////////////////////////////////////
    // Widths that carry a meaning
    //////////////////////////////////////////////////

    // Knob position, 0 to 19
    typedef logic [4:0] enc_pos_t;
    // Digit enables, active low, digit 0 is bit 0
    typedef logic [3:0] anode_t;
    // Segments, gfedcba order, active low
    typedef logic [6:0] seg_t;

    //////////////////////////////////////////////////
    // Position range and timing defaults
    //////////////////////////////////////////////////

    localparam enc_pos_t POS_MAX = 5'd19;

    // Stable cycles before a filtered line follows its input
    localparam logic [15:0] DEBOUNCE_TICKS = 16'd50_000;
    // Cycles per digit phase of the display refresh
    localparam logic [17:0] DIGIT_TICKS = 18'd100_000;

    //////////////////////////////////////////////////
    // Segment patterns
    //////////////////////////////////////////////////

    // Index is the decimal digit
    localparam seg_t SEG_DIGIT [0:9] = '{
        7'b1000000,  // 0
        7'b1111001,  // 1
        7'b0100100,  // 2
        7'b0110000,  // 3
        7'b0011001,  // 4
        7'b0010010,  // 5
        7'b0000010,  // 6
        7'b1111000,  // 7
        7'b0000000,  // 8
        7'b0010000   // 9
    };

    // All segments dark
    localparam seg_t SEG_BLANK = 7'b1111111;

    // Quadrature decoder progress, CW and CCW paths back to rest
    typedef enum logic [2:0] {
        QS_REST, QS_CW1, QS_CW2, QS_CW3, QS_CCW1, QS_CCW2, QS_CCW3
    } quad_state_t;

endpackage

//--- hdl/enc_input_filter.sv
`timescale 1ns/1ps

module enc_input_filter #(
    parameter int unsigned       width          = 3,
    parameter int unsigned       debounce_ticks = pmod_enc_pkg::DEBOUNCE_TICKS,
    parameter logic [width-1:0]  rst_val        = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [width-1:0] raw,
    output logic [width-1:0] clean
);

    // Counter wide enough to hold debounce_ticks - 1
    localparam int unsigned cnt_w = $clog2(debounce_ticks + 1);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(debounce_ticks - 1);

    //////////////////////////////////////////////////
    // Two-flop synchronizer
    //////////////////////////////////////////////////

    logic [width-1:0] sync_q1;
    logic [width-1:0] sync_q2;

    // Reset to the idle level so nothing moves at startup
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1 <= rst_val;
            sync_q2 <= rst_val;
        end else begin
            sync_q1 <= raw;
            sync_q2 <= sync_q1;
        end
    end

    //////////////////////////////////////////////////
    // Per-bit stable counter
    //////////////////////////////////////////////////

    for (genvar i = 0; i < width; i++) begin : g_bit
        logic [cnt_w-1:0] stable_cnt;
        logic             clean_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                stable_cnt <= '0;
                clean_q    <= rst_val[i];
            end else if (sync_q2[i] == clean_q) begin
                // Input agrees with output, any bounce so far is forgotten
                stable_cnt <= '0;
            end else if (stable_cnt == last_cnt) begin
                // Differed for debounce_ticks cycles in a row
                clean_q    <= sync_q2[i];
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end

        assign clean[i] = clean_q;
    end

endmodule

//--- hdl/enc_quad_decode.sv
`timescale 1ns/1ps

module enc_quad_decode (
    input  logic clk,
    input  logic rst,
    input  logic a,
    input  logic b,
    output logic step_cw,
    output logic step_ccw
);

    import pmod_enc_pkg::*;

    quad_state_t state;
    quad_state_t state_next;
    logic [1:0]  ab;
    logic        cw_hit;
    logic        ccw_hit;

    // A in the upper bit to match the AB notation of the sequences
    assign ab = {a, b};

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    // Each state holds on its own level and advances on the next Gray level
    // Anything else drops back to rest without a step
    always_comb begin
        state_next = state;
        cw_hit     = 1'b0;
        ccw_hit    = 1'b0;
        case (state)
            QS_REST: begin
                case (ab)
                    2'b01:   state_next = QS_CW1;
                    2'b10:   state_next = QS_CCW1;
                    default: state_next = QS_REST;
                endcase
            end
            // Clockwise path 01, 00, 10
            QS_CW1: begin
                if (ab == 2'b00) state_next = QS_CW2;
                else if (ab != 2'b01) state_next = QS_REST;
            end
            QS_CW2: begin
                if (ab == 2'b10) state_next = QS_CW3;
                else if (ab != 2'b00) state_next = QS_REST;
            end
            QS_CW3: begin
                if (ab == 2'b11) begin
                    state_next = QS_REST;
                    cw_hit     = 1'b1;
                end else if (ab != 2'b10) begin
                    state_next = QS_REST;
                end
            end
            // Counter-clockwise path 10, 00, 01
            QS_CCW1: begin
                if (ab == 2'b00) state_next = QS_CCW2;
                else if (ab != 2'b10) state_next = QS_REST;
            end
            QS_CCW2: begin
                if (ab == 2'b01) state_next = QS_CCW3;
                else if (ab != 2'b00) state_next = QS_REST;
            end
            QS_CCW3: begin
                if (ab == 2'b11) begin
                    state_next = QS_REST;
                    ccw_hit    = 1'b1;
                end else if (ab != 2'b01) begin
                    state_next = QS_REST;
                end
            end
            default: state_next = QS_REST;
        endcase
    end

    //////////////////////////////////////////////////
    // State and step registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= QS_REST;
            step_cw  <= 1'b0;
            step_ccw <= 1'b0;
        end else begin
            state    <= state_next;
            step_cw  <= cw_hit;
            step_ccw <= ccw_hit;
        end
    end

    // Only one direction per detent
    assert property (@(posedge clk) disable iff (rst) !(step_cw && step_ccw));

endmodule

//--- hdl/enc_position_counter.sv
`timescale 1ns/1ps

module enc_position_counter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   step_cw,
    input  logic                   step_ccw,
    input  logic                   clear,
    output pmod_enc_pkg::enc_pos_t pos
);

    import pmod_enc_pkg::*;

    enc_pos_t pos_inc;
    enc_pos_t pos_dec;

    //////////////////////////////////////////////////
    // Wrap at both ends
    //////////////////////////////////////////////////

    // 19 rolls over to 0
    assign pos_inc = (pos == POS_MAX) ? 5'd0 : pos + 5'd1;
    // 0 rolls under to 19
    assign pos_dec = (pos == 5'd0) ? POS_MAX : pos - 5'd1;

    // Button wins over any step in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pos <= '0;
        end else if (clear) begin
            pos <= '0;
        end else if (step_cw) begin
            pos <= pos_inc;
        end else if (step_ccw) begin
            pos <= pos_dec;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Range holds whatever the decoder sends
    assert property (@(posedge clk) disable iff (rst) pos <= POS_MAX);

endmodule

//--- hdl/seg7_control.sv
`timescale 1ns/1ps

module seg7_control #(
    parameter int unsigned digit_ticks = pmod_enc_pkg::DIGIT_TICKS
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sw,
    input  pmod_enc_pkg::enc_pos_t pos,
    output pmod_enc_pkg::anode_t   anode,
    output pmod_enc_pkg::seg_t     seg_out
);

    import pmod_enc_pkg::*;

    // Refresh period is two digit phases
    localparam int unsigned cnt_w = $clog2(2 * digit_ticks);
    localparam logic [cnt_w-1:0] tens_cnt = cnt_w'(digit_ticks);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(2 * digit_ticks - 1);

    logic [cnt_w-1:0] refresh_cnt;
    enc_pos_t         ones_val;
    logic [3:0]       ones_digit;
    logic             tens_on;
    seg_t             ones_seg;

    //////////////////////////////////////////////////
    // Digit split
    //////////////////////////////////////////////////

    // Tens digit is 0 or 1 since pos never exceeds 19
    assign tens_on = (pos > 5'd9);

    // Modulo 10 by one subtraction
    assign ones_val   = tens_on ? pos - 5'd10 : pos;
    assign ones_digit = ones_val[3:0];

    // Lookup of the ones digit
    assign ones_seg = SEG_DIGIT[ones_digit];

    //////////////////////////////////////////////////
    // Refresh and multiplexing
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            refresh_cnt <= '0;
            anode       <= 4'b1111;
            seg_out     <= SEG_BLANK;
        end else if (!sw) begin
            // Dark display restarts from the ones phase when switched on
            refresh_cnt <= '0;
            anode       <= 4'b1111;
            seg_out     <= SEG_BLANK;
        end else begin
            // Phase 0 shows the ones digit
            if (refresh_cnt == '0) begin
                anode   <= 4'b1110;
                seg_out <= ones_seg;
            end else if (refresh_cnt == tens_cnt) begin
                // Phase 1 lights the tens digit only above 9
                if (tens_on) begin
                    anode   <= 4'b1101;
                    seg_out <= SEG_DIGIT[1];
                end else begin
                    anode   <= 4'b1111;
                    seg_out <= SEG_BLANK;
                end
            end

            // Wraps after two phases
            if (refresh_cnt == last_cnt) begin
                refresh_cnt <= '0;
            end else begin
                refresh_cnt <= refresh_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Never two digits driven at once
    assert property (@(posedge clk) disable iff (rst) $countones(~anode) <= 1);

endmodule

//--- hdl/pmod_enc_top.sv
`timescale 1ns/1ps

module pmod_enc_top #(
    parameter int unsigned debounce_ticks = pmod_enc_pkg::DEBOUNCE_TICKS,
    parameter int unsigned digit_ticks    = pmod_enc_pkg::DIGIT_TICKS
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enc_a,
    input  logic                 enc_b,
    input  logic                 enc_btn,
    input  logic                 sw,
    output pmod_enc_pkg::anode_t anode,
    output pmod_enc_pkg::seg_t   seg_out
);

    logic [2:0]             raw_in;
    logic [2:0]             clean_out;
    logic                   a_clean;
    logic                   b_clean;
    logic                   btn_clean;
    logic                   step_cw;
    logic                   step_ccw;
    pmod_enc_pkg::enc_pos_t pos;

    //////////////////////////////////////////////////
    // Input conditioning
    //////////////////////////////////////////////////

    // Bit order btn, B, A
    assign raw_in = {enc_btn, enc_b, enc_a};

    // A and B idle high, button idles low
    enc_input_filter #(
        .width          (3),
        .debounce_ticks (debounce_ticks),
        .rst_val        (3'b011)
    ) u_input_filter (
        .clk   (clk),
        .rst   (rst),
        .raw   (raw_in),
        .clean (clean_out)
    );

    assign a_clean   = clean_out[0];
    assign b_clean   = clean_out[1];
    assign btn_clean = clean_out[2];

    //////////////////////////////////////////////////
    // Decode, count, display
    //////////////////////////////////////////////////

    enc_quad_decode u_quad_decode (
        .clk      (clk),
        .rst      (rst),
        .a        (a_clean),
        .b        (b_clean),
        .step_cw  (step_cw),
        .step_ccw (step_ccw)
    );

    // Button clears the position
    enc_position_counter u_position_counter (
        .clk      (clk),
        .rst      (rst),
        .step_cw  (step_cw),
        .step_ccw (step_ccw),
        .clear    (btn_clean),
        .pos      (pos)
    );

    seg7_control #(
        .digit_ticks (digit_ticks)
    ) u_seg7_control (
        .clk     (clk),
        .rst     (rst),
        .sw      (sw),
        .pos     (pos),
        .anode   (anode),
        .seg_out (seg_out)
    );

endmodule

//--- tests/pmod_enc_tb.sv
`timescale 1ns/1ps

module pmod_enc_tb;

    // Reduced ticks keep the run short
    localparam int debounce_ticks = 4;
    localparam int digit_ticks    = 8;
    localparam int hold_cycles    = debounce_ticks + 4;
    // Watchdog limit is twice the task count times the longest task
    localparam int task_count     = 100;
    localparam int longest_cycles = 6 * digit_ticks + 2;
    localparam int timeout_ns     = task_count * longest_cycles * 20 * 2;

    logic       clk = 1'b0;
    logic       rst;
    logic       enc_a;
    logic       enc_b;
    logic       enc_btn;
    logic       sw;
    logic [3:0] anode;
    logic [6:0] seg_out;

    int          model_pos;
    int          errors;
    int          checks;
    int unsigned lcg_state;

    pmod_enc_top #(
        .debounce_ticks (debounce_ticks),
        .digit_ticks    (digit_ticks)
    ) u_pmod_enc_top (
        .clk     (clk),
        .rst     (rst),
        .enc_a   (enc_a),
        .enc_b   (enc_b),
        .enc_btn (enc_btn),
        .sw      (sw),
        .anode   (anode),
        .seg_out (seg_out)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Reference models
    //////////////////////////////////////////////////

    // Active-low gfedcba pattern of a decimal digit
    function automatic logic [6:0] expected_seg(input int d);
        case (d)
            0: return 7'b1000000;
            1: return 7'b1111001;
            2: return 7'b0100100;
            3: return 7'b0110000;
            4: return 7'b0011001;
            5: return 7'b0010010;
            6: return 7'b0000010;
            7: return 7'b1111000;
            8: return 7'b0000000;
            9: return 7'b0010000;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus tasks that start and end on a falling edge
    //////////////////////////////////////////////////

    // One Gray level held long enough to pass the filter
    task automatic drive_ab(input logic a_lvl, input logic b_lvl);
        enc_a = a_lvl;
        enc_b = b_lvl;
        repeat (hold_cycles) @(negedge clk);
    endtask

    task automatic rotate_cw;
        drive_ab(1'b0, 1'b1);
        drive_ab(1'b0, 1'b0);
        drive_ab(1'b1, 1'b0);
        drive_ab(1'b1, 1'b1);
        model_pos = (model_pos == 19) ? 0 : model_pos + 1;
    endtask

    task automatic rotate_ccw;
        drive_ab(1'b1, 1'b0);
        drive_ab(1'b0, 1'b0);
        drive_ab(1'b0, 1'b1);
        drive_ab(1'b1, 1'b1);
        model_pos = (model_pos == 0) ? 19 : model_pos - 1;
    endtask

    task automatic press_btn;
        enc_btn = 1'b1;
        repeat (hold_cycles) @(negedge clk);
        enc_btn = 1'b0;
        repeat (hold_cycles) @(negedge clk);
        model_pos = 0;
    endtask

    // Too short for the debouncer
    task automatic glitch;
        enc_a = 1'b0;
        repeat (2) @(negedge clk);
        enc_a = 1'b1;
        repeat (hold_cycles) @(negedge clk);
    endtask

    // A glitch at level 10 would break the rotation if it got through the filter
    task automatic rotate_cw_with_glitch;
        drive_ab(1'b0, 1'b1);
        drive_ab(1'b0, 1'b0);
        drive_ab(1'b1, 1'b0);
        glitch();
        drive_ab(1'b1, 1'b1);
        model_pos = (model_pos == 19) ? 0 : model_pos + 1;
    endtask

    //////////////////////////////////////////////////
    // Display checks
    //////////////////////////////////////////////////

    task automatic check_display;
        logic [6:0] ones_seen;
        logic [6:0] tens_seen;
        logic       ones_hit;
        logic       tens_hit;
        // Two refresh periods let the new position reach the digits
        repeat (4 * digit_ticks) @(negedge clk);
        ones_hit  = 1'b0;
        tens_hit  = 1'b0;
        ones_seen = 7'h7f;
        tens_seen = 7'h7f;
        repeat (2 * digit_ticks) begin
            @(negedge clk);
            if (anode == 4'b1110) begin
                ones_hit  = 1'b1;
                ones_seen = seg_out;
            end
            if (anode == 4'b1101) begin
                tens_hit  = 1'b1;
                tens_seen = seg_out;
            end
        end
        checks++;
        if (!ones_hit) begin
            $display("Ones digit never enabled at %0t, position %0d", $time, model_pos);
            errors++;
        end else if (ones_seen != expected_seg(model_pos % 10)) begin
            $display("[ERROR] %0t seg_out (ones): got %b, expected %b", $time,
                     ones_seen, expected_seg(model_pos % 10));
            errors++;
        end
        if (model_pos > 9 && !tens_hit) begin
            $display("Tens digit dark at %0t for position %0d", $time, model_pos);
            errors++;
        end else if (model_pos > 9 && tens_seen != expected_seg(1)) begin
            $display("[ERROR] %0t seg_out (tens): got %b, expected %b", $time,
                     tens_seen, expected_seg(1));
            errors++;
        end else if (model_pos <= 9 && tens_hit) begin
            $display("Tens digit lit at %0t for position %0d", $time, model_pos);
            errors++;
        end
    endtask

    // Switch low keeps every digit dark
    task automatic check_blank;
        int         lit;
        logic [3:0] lit_val;
        lit     = 0;
        lit_val = 4'b1111;
        sw      = 1'b0;
        repeat (2) @(negedge clk);
        repeat (2 * digit_ticks) begin
            @(negedge clk);
            if (anode != 4'b1111) begin
                lit++;
                lit_val = anode;
            end
        end
        checks++;
        if (lit != 0) begin
            $display("[ERROR] %0t anode: got %b, expected 1111", $time, lit_val);
            errors++;
        end
        sw = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial begin
        #(timeout_ns);
        $display("Watchdog expired, the tests did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        enc_a     = 1'b1;
        enc_b     = 1'b1;
        enc_btn   = 1'b0;
        sw        = 1'b1;
        model_pos = 0;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'd89;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Reset value and then blanking
        check_display();
        check_blank();

        // Count up past 9
        repeat (5) rotate_cw();
        check_display();
        repeat (7) rotate_cw();
        check_display();

        // Wrap at both ends
        press_btn();
        rotate_ccw();
        check_display();
        rotate_cw();
        check_display();

        // Button clear and a glitch on A inside a rotation
        rotate_cw();
        rotate_cw();
        check_display();
        press_btn();
        check_display();
        rotate_cw_with_glitch();
        check_display();

        // Broken sequence 11, 01, 11 gives no step
        drive_ab(1'b0, 1'b1);
        drive_ab(1'b1, 1'b1);
        check_display();

        // Random directions
        repeat (30) begin
            lcg_state = lcg_next(lcg_state);
            if (lcg_state[30]) rotate_cw();
            else rotate_ccw();
            check_display();
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- pmod_enc_top.f
hdl/pmod_enc_pkg.sv
hdl/enc_input_filter.sv
hdl/enc_quad_decode.sv
hdl/enc_position_counter.sv
hdl/seg7_control.sv
hdl/pmod_enc_top.sv
tests/pmod_enc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module pmod_enc_tb -f pmod_enc_top.f -o sim_pmod_enc
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_pmod_enc)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
